// ==== Makefile ====
# Verilator build for the FIR filter testbench.

TOOL      = verilator
FLAGS     = --binary --timing
LINTFLAGS = --lint-only --timing
TOP       = firFilterTb
FILELIST  = list.f
BUILDDIR  = obj_dir
LOG       = sim.log
PASSTEXT  = ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

# Lint the RTL top level on its own, then the testbench with it.
lint:
	$(TOOL) $(LINTFLAGS) -Ilogic logic/firPkg.sv logic/firControl.sv logic/firTap.sv \
		logic/firSum.sv logic/firFilter.sv --top-module firFilter
	$(TOOL) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

# The run passes only if the log holds the pass line.
sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASSTEXT)" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

// ==== list.f ====
+incdir+logic
logic/firPkg.sv
logic/firControl.sv
logic/firTap.sv
logic/firSum.sv
logic/firFilter.sv
test/firFilterTb.sv

// ==== logic/firControl.sv ====
// ############################
// FIR mode machine.
// Strobes are plain levels sampled each clock.
// loadData outside FILTER is dropped.
// ############################

`timescale 1ns/1ps

module firControl (
	input  logic                clock,
	input  logic                reset,
	input  logic                loadCoefficients,
	input  logic                coefficientsSet,
	input  logic                loadData,
	input  logic                stopData,
	input  firPkg::sampleT      coeffIn,
	input  firPkg::sampleT      dataIn,
	output firPkg::sampleT      coeffHead,
	output firPkg::sampleT      sampleHead,
	output firPkg::tapControlT  tapControl,
	output logic                sumEnable
);

	// Current and next mode.
	firPkg::firStateT state;
	firPkg::firStateT nextState;

	// High when a sample enters the chain on this clock edge.
	logic sampleAccept;

	// Next-state logic.
	// The machine only leaves a mode on its own exit strobe.
	always_comb begin
		nextState = state;
		unique case (state)
			firPkg::IDLE: begin
				if (loadCoefficients) begin
					nextState = firPkg::LOAD_COEFFICIENTS;
				end
			end
			firPkg::LOAD_COEFFICIENTS: begin
				// The coefficient on this last cycle is still shifted in.
				if (coefficientsSet) begin
					nextState = firPkg::FILTER;
				end
			end
			firPkg::FILTER: begin
				if (stopData) begin
					nextState = firPkg::STOP;
				end
			end
			firPkg::STOP: begin
				// Stop lasts exactly one cycle while the history is wiped.
				nextState = firPkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= firPkg::IDLE;
		end else begin
			state <= nextState;
		end
	end

	// A sample is taken only while filtering.
	// A sample that arrives with stopData is still accepted.
	assign sampleAccept = (state == firPkg::FILTER) && loadData;

	// Every cycle in the load mode pushes one coefficient into the chain.
	assign tapControl.coeffShift   = (state == firPkg::LOAD_COEFFICIENTS);
	assign tapControl.sampleShift  = sampleAccept;
	assign tapControl.clearSamples = (state == firPkg::STOP);

	// The chain heads take the raw inputs.
	// The shift strobes above decide whether the taps use them.
	assign coeffHead  = coeffIn;
	assign sampleHead = dataIn;

	// The taps capture the sample at the accept edge and multiply at once.
	// The summer therefore registers one edge later.
	always_ff @(posedge clock) begin
		if (reset) begin
			sumEnable <= 1'b0;
		end else begin
			sumEnable <= sampleAccept;
		end
	end

endmodule

// ==== logic/firFilter.sv ====
// ############################
// Direct-form FIR top level.
// Coefficients load at run time.
// No back-pressure on outValid.
// ############################

`timescale 1ns/1ps

`include "fir_macros.svh"

module firFilter (
	input  logic           clock,
	input  logic           reset,
	input  logic           loadCoefficients,
	input  logic           coefficientsSet,
	input  logic           loadData,
	input  logic           stopData,
	input  firPkg::sampleT coeffIn,
	input  firPkg::sampleT dataIn,
	output firPkg::sumT    dataOut,
	output logic           outValid
);

	// Chain heads and the broadcast strobes from the control block.
	firPkg::sampleT     coeffHead;
	firPkg::sampleT     sampleHead;
	firPkg::tapControlT tapControl;
	logic               sumEnable;

	// Links into and out of every tap.
	firPkg::tapLinkT linkIn  [`FIR_TAPS];
	firPkg::tapLinkT linkOut [`FIR_TAPS];

	// One product per tap, gathered for the summer.
	firPkg::productT [`FIR_TAPS-1:0] products;

	firControl control (
		.clock            (clock),
		.reset            (reset),
		.loadCoefficients (loadCoefficients),
		.coefficientsSet  (coefficientsSet),
		.loadData         (loadData),
		.stopData         (stopData),
		.coeffIn          (coeffIn),
		.dataIn           (dataIn),
		.coeffHead        (coeffHead),
		.sampleHead       (sampleHead),
		.tapControl       (tapControl),
		.sumEnable        (sumEnable)
	);

	for (genvar i = 0; i < `FIR_TAPS; i++) begin : tapStage
		// Samples enter at tap 0 and move toward the last tap.
		if (i == 0) begin : sampleEntry
			assign linkIn[i].sample = sampleHead;
		end else begin : sampleChain
			assign linkIn[i].sample = linkOut[i-1].sample;
		end

		// Coefficients enter at the last tap and move toward tap 0.
		// The first one shifted in therefore ends up at tap 0.
		if (i == `FIR_TAPS - 1) begin : coeffEntry
			assign linkIn[i].coeff = coeffHead;
		end else begin : coeffChain
			assign linkIn[i].coeff = linkOut[i+1].coeff;
		end

		firTap tap (
			.clock      (clock),
			.reset      (reset),
			.tapControl (tapControl),
			.linkIn     (linkIn[i]),
			.linkOut    (linkOut[i]),
			.product    (products[i])
		);
	end

	firSum summer (
		.clock     (clock),
		.reset     (reset),
		.products  (products),
		.sumEnable (sumEnable),
		.dataOut   (dataOut),
		.outValid  (outValid)
	);

endmodule

// ==== logic/firPkg.sv ====
// ############################
// Shared FIR types.
// Widths follow fir_macros.svh.
// ############################

`include "fir_macros.svh"

package firPkg;

	// Mode of the control machine.
	// All four codes are used, so no state is unreachable.
	typedef enum logic [1:0] {
		IDLE              = 2'd0,
		LOAD_COEFFICIENTS = 2'd1,
		FILTER            = 2'd2,
		STOP              = 2'd3
	} firStateT;

	// One signed data word.
	// Samples and coefficients share this width.
	typedef logic signed [`FIR_DATA_WIDTH-1:0] sampleT;

	// Values passed from one tap to its neighbour.
	// The coefficient part moves down the chain and the sample part moves up.
	typedef struct packed {
		sampleT coeff;
		sampleT sample;
	} tapLinkT;

	// Strobes sent from the control block to every tap at once.
	typedef struct packed {
		logic coeffShift;
		logic sampleShift;
		logic clearSamples;
	} tapControlT;

	// Full-width signed product of one coefficient and one sample.
	typedef logic signed [`FIR_PRODUCT_WIDTH-1:0] productT;

	// Filter result at full width.
	typedef logic signed [`FIR_SUM_WIDTH-1:0] sumT;

endpackage

// ==== logic/firSum.sv ====
// ############################
// Tap product adder.
// One register stage.
// Result is full width with no
// rounding or saturation.
// ############################

`timescale 1ns/1ps

`include "fir_macros.svh"

module firSum (
	input  logic                                clock,
	input  logic                                reset,
	input  firPkg::productT [`FIR_TAPS-1:0]     products,
	input  logic                                sumEnable,
	output firPkg::sumT                         dataOut,
	output logic                                outValid
);

	// Combinational total of all tap products.
	firPkg::sumT total;

	// Each product is sign-extended to the result width before it is added.
	// The extra bits absorb the growth from adding all taps.
	always_comb begin
		total = '0;
		for (int i = 0; i < `FIR_TAPS; i++) begin
			total = total + firPkg::sumT'($signed(products[i]));
		end
	end

	// A new total is taken only when a fresh sample has reached the taps.
	// Between results the output keeps its last value.
	always_ff @(posedge clock) begin
		if (reset) begin
			dataOut <= '0;
		end else if (sumEnable) begin
			dataOut <= total;
		end
	end

	// The valid flag follows the enable and so lasts one cycle per result.
	// Back-to-back samples give a valid on every cycle.
	always_ff @(posedge clock) begin
		if (reset) begin
			outValid <= 1'b0;
		end else begin
			outValid <= sumEnable;
		end
	end

endmodule

// ==== logic/firTap.sv ====
// ############################
// One FIR tap cell.
// Product is combinational.
// Clear has priority over a shift.
// ############################

`timescale 1ns/1ps

module firTap (
	input  logic               clock,
	input  logic               reset,
	input  firPkg::tapControlT tapControl,
	input  firPkg::tapLinkT    linkIn,
	output firPkg::tapLinkT    linkOut,
	output firPkg::productT    product
);

	// The coefficient and the delayed sample held by this tap.
	firPkg::sampleT coeff;
	firPkg::sampleT sample;

	// The coefficient register moves one place down the chain per load cycle.
	always_ff @(posedge clock) begin
		if (reset) begin
			coeff <= '0;
		end else if (tapControl.coeffShift) begin
			coeff <= linkIn.coeff;
		end
	end

	// The sample register forms one stage of the delay line.
	// A stop wipes the whole history in a single cycle.
	always_ff @(posedge clock) begin
		if (reset) begin
			sample <= '0;
		end else if (tapControl.clearSamples) begin
			sample <= '0;
		end else if (tapControl.sampleShift) begin
			sample <= linkIn.sample;
		end
	end

	// The neighbours see the stored values.
	// The top level routes each half in its own direction.
	assign linkOut.coeff  = coeff;
	assign linkOut.sample = sample;

	// Both operands are signed.
	// The multiply is evaluated at the full product width.
	assign product = coeff * sample;

endmodule

// ==== logic/fir_macros.svh ====
// ############################
// Tap count and word widths.
// FIR_TAPS must be 2 or more.
// The sum width covers the worst case with no overflow.
// ############################

`ifndef FIR_MACROS_SVH
`define FIR_MACROS_SVH

// Number of taps in the filter chain.
// Each tap holds one coefficient and one delayed sample.
`define FIR_TAPS 16

// Signed width of every sample and every coefficient.
`define FIR_DATA_WIDTH 8

// A signed product needs the sum of both operand widths.
`define FIR_PRODUCT_WIDTH (2 * `FIR_DATA_WIDTH)

// The adder tree grows by one bit for each doubling of the tap count.
// With 16 taps of 8-bit data this comes to 20 bits.
`define FIR_SUM_WIDTH (`FIR_PRODUCT_WIDTH + $clog2(`FIR_TAPS))

`endif

// ==== test/firFilterTb.sv ====
// ############################
// Directed FIR testbench.
// A queue model mirrors the taps.
// Results are checked the edge after
// the edge that took the sample.
// ############################

`timescale 1ns/1ps

`include "fir_macros.svh"

module firFilterTb;

	localparam int clockPeriod = 40;
	localparam int testCount = 5;
	localparam int samplesPerTest = 64;
	localparam int watchdogCycles = testCount * samplesPerTest + 200;

	logic           clock;
	logic           reset;
	logic           loadCoefficients;
	logic           coefficientsSet;
	logic           loadData;
	logic           stopData;
	firPkg::sampleT coeffIn;
	firPkg::sampleT dataIn;
	firPkg::sumT    dataOut;
	logic           outValid;

	// Reference model: coeffModel[i] is h(i) and historyModel[i] is x(n-i).
	firPkg::sampleT coeffModel[$];
	firPkg::sampleT historyModel[$];
	firPkg::sampleT pendingCoeffs[$];
	bit             filtering;

	// Results in flight with the clock edge at which each one is due.
	firPkg::sumT expectQueue[$];
	int          dueQueue[$];
	firPkg::sumT lastOut;

	int          cycleCount;
	int          errorCount;
	int          checkCount;
	int unsigned lcgState;

	firFilter u_dut (
		.clock            (clock),
		.reset            (reset),
		.loadCoefficients (loadCoefficients),
		.coefficientsSet  (coefficientsSet),
		.loadData         (loadData),
		.stopData         (stopData),
		.coeffIn          (coeffIn),
		.dataIn           (dataIn),
		.dataOut          (dataOut),
		.outValid         (outValid)
	);

	initial begin
		clock = 1'b0;
		forever #(clockPeriod / 2) clock = ~clock;
	end

	// Counts rising edges so that each result knows when it is due.
	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
	end

	// Hard stop in case the DUT or a test never finishes.
	initial begin
		#(clockPeriod * watchdogCycles);
		$display("Watchdog expired after %0d clock periods, the run did not finish.",
			watchdogCycles);
		$display("CHECKS FAILED");
		$finish;
	end

	function automatic int unsigned nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// The upper bits of an LCG are the most random ones.
	function automatic firPkg::sampleT randomWord();
		int unsigned value;
		value = nextRandom();
		return firPkg::sampleT'(value[23:16]);
	endfunction

	// Sum of h(i) times x(n-i) over all taps, kept at full precision.
	function automatic firPkg::sumT expectedSum();
		longint acc;
		int     c;
		int     x;
		acc = 0;
		for (int i = 0; i < `FIR_TAPS; i++) begin
			c = coeffModel[i];
			x = historyModel[i];
			acc += longint'(c * x);
		end
		return firPkg::sumT'(acc);
	endfunction

	task automatic checkSum(input firPkg::sumT expected, input firPkg::sumT actual);
		checkCount++;
		if (actual !== expected) begin
			$display("[ERROR] %0t dataOut expected %0d actual %0d", $time, expected, actual);
			errorCount++;
		end
	endtask

	task automatic checkValid(input logic expected, input logic actual);
		checkCount++;
		if (actual !== expected) begin
			$display("[ERROR] %0t outValid expected %b actual %b", $time, expected, actual);
			errorCount++;
		end
	endtask

	// Looks at the outputs 1 ns after every edge, once the registers have settled.
	// Between results dataOut must hold the last value.
	always @(posedge clock) begin
		#1;
		if (!reset) begin
			if (dueQueue.size() > 0 && dueQueue[0] == cycleCount) begin
				if (outValid !== 1'b1) begin
					$display("No outValid pulse at %0t for a sample taken one edge earlier.",
						$time);
					errorCount++;
				end
				checkSum(expectQueue[0], dataOut);
				lastOut = expectQueue.pop_front();
				void'(dueQueue.pop_front());
			end else begin
				checkValid(1'b0, outValid);
				checkSum(lastOut, dataOut);
			end
		end
	end

	// Inputs change 2 ns after the rising edge.
	task automatic stepCycle();
		@(posedge clock);
		#2;
	endtask

	task automatic idleCycles(input int count);
		repeat (count) stepCycle();
	endtask

	// Starts from idle and shifts in every queued coefficient.
	// The last one goes in together with coefficientsSet.
	task automatic loadCoefficientSet();
		int count;
		count = pendingCoeffs.size();
		loadCoefficients = 1'b1;
		stepCycle();
		loadCoefficients = 1'b0;
		for (int j = 0; j < count; j++) begin
			coeffIn = pendingCoeffs[j];
			coefficientsSet = (j == count - 1);
			stepCycle();
			coeffModel.push_back(pendingCoeffs[j]);
			void'(coeffModel.pop_front());
		end
		coefficientsSet = 1'b0;
		coeffIn = '0;
		pendingCoeffs.delete();
		filtering = 1'b1;
	endtask

	// Offers one sample. Outside FILTER the DUT must ignore it.
	task automatic sendSample(input firPkg::sampleT value);
		dataIn = value;
		loadData = 1'b1;
		if (filtering) begin
			historyModel.push_front(value);
			void'(historyModel.pop_back());
			expectQueue.push_back(expectedSum());
			dueQueue.push_back(cycleCount + 2);
		end
		stepCycle();
		loadData = 1'b0;
	endtask

	task automatic waitForResults();
		int waited;
		waited = 0;
		while (expectQueue.size() > 0 && waited < 8) begin
			stepCycle();
			waited++;
		end
		if (expectQueue.size() > 0) begin
			$display("Timed out at %0t with %0d results never delivered.",
				$time, expectQueue.size());
			errorCount++;
			expectQueue.delete();
			dueQueue.delete();
		end
	endtask

	// One cycle into STOP, one more back to IDLE with the history wiped.
	task automatic stopStream();
		stopData = 1'b1;
		stepCycle();
		stopData = 1'b0;
		stepCycle();
		foreach (historyModel[i]) historyModel[i] = '0;
		filtering = 1'b0;
	endtask

	task automatic resetBehaviour();
		idleCycles(4);
		sendSample(8'sd5);
		idleCycles(4);
	endtask

	// An impulse walks through the taps and reads out h(0), h(1) and so on.
	task automatic impulseResponse();
		for (int j = 0; j < `FIR_TAPS; j++) begin
			pendingCoeffs.push_back(firPkg::sampleT'(j * 13 - 97));
		end
		loadCoefficientSet();
		sendSample(8'sd1);
		for (int j = 0; j < `FIR_TAPS; j++) begin
			sendSample(8'sd0);
		end
		waitForResults();
		stopStream();
	endtask

	task automatic randomStream();
		pendingCoeffs.push_back(-8'sd128);
		for (int j = 1; j < `FIR_TAPS - 1; j++) begin
			pendingCoeffs.push_back(randomWord());
		end
		pendingCoeffs.push_back(8'sd127);
		loadCoefficientSet();
		for (int j = 0; j < samplesPerTest; j++) begin
			if (j % 16 == 3) begin
				sendSample(-8'sd128);
			end else if (j % 16 == 9) begin
				sendSample(8'sd127);
			end else begin
				sendSample(randomWord());
			end
		end
		waitForResults();
	endtask

	// Idle cycles between samples must leave dataOut alone.
	task automatic streamWithGaps();
		int gap;
		for (int j = 0; j < 40; j++) begin
			sendSample(randomWord());
			gap = int'(nextRandom() % 32'd3);
			idleCycles(gap);
		end
		waitForResults();
	endtask

	task automatic stopAndReload();
		stopStream();
		sendSample(8'sd77);
		idleCycles(3);
		for (int j = 0; j < `FIR_TAPS + 5; j++) begin
			pendingCoeffs.push_back(randomWord());
		end
		loadCoefficientSet();
		for (int j = 0; j < 32; j++) begin
			sendSample(randomWord());
		end
		waitForResults();
	endtask

	initial begin
		reset = 1'b1;
		loadCoefficients = 1'b0;
		coefficientsSet = 1'b0;
		loadData = 1'b0;
		stopData = 1'b0;
		coeffIn = '0;
		dataIn = '0;
		cycleCount = 0;
		errorCount = 0;
		checkCount = 0;
		lcgState = 23;
		lastOut = '0;
		filtering = 1'b0;
		for (int i = 0; i < `FIR_TAPS; i++) begin
			coeffModel.push_back('0);
			historyModel.push_back('0);
		end
		repeat (8) @(posedge clock);
		#2;
		reset = 1'b0;

		resetBehaviour();
		impulseResponse();
		randomStream();
		streamWithGaps();
		stopAndReload();
		idleCycles(2);

		$display("Errors: %0d in %0d checks", errorCount, checkCount);
		if (errorCount == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule
